//--- build.f
+incdir+include
source/dispatchPkg.sv
source/laneDecode.sv
source/resourceCheck.sv
source/packetBuild.sv
source/dispatchLatch.sv
source/dispatchTop.sv
testbench/dispatchTb.sv

//--- include/dispatch_consts.svh
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// Bundle geometry
`define DISPATCH_WIDTH       4

// Branch checkpoints, one mask bit each
`define CHECKPOINTS          8
`define CHECKPOINTS_LOG      3

// Register and instruction fields
`define SIZE_PHYSICAL_LOG    6
`define SIZE_RMT_LOG         5
`define SIZE_PC              32
`define SIZE_OPCODE          8
`define SIZE_IMMEDIATE       16

// Load queue and store queue share one size
`define SIZE_LSQ             16
`define SIZE_LSQ_LOG         4

`define SIZE_ISSUEQ          32
`define SIZE_ISSUEQ_LOG      5

`define SIZE_ACTIVELIST      64
`define SIZE_ACTIVELIST_LOG  6

`endif

//--- source/dispatchLatch.sv
`default_nettype none

`include "dispatch_consts.svh"

module dispatchLatch #(
  parameter type payloadT = logic [7:0]
) (
  input  wire logic    clk,
  input  wire logic    rstN_i,
  input  wire logic    load_i,                     // Back end accepts the bundle
  input  wire payloadT payload_i [`DISPATCH_WIDTH],
  output payloadT      payload_o [`DISPATCH_WIDTH],
  output logic         valid_o                     // Bundle in the register is new
);

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      valid_o <= 1'b0;
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        payload_o[i] <= '0;
      end
    end else begin
      valid_o <= load_i;                           // Valid for one cycle per accept
      if (load_i) begin
        payload_o <= payload_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/dispatchPkg.sv
`default_nettype none

`include "dispatch_consts.svh"

package dispatchPkg;

  // Instruction as it leaves rename
  typedef struct packed {
    logic [`SIZE_PC-1:0]           pc;
    logic [`SIZE_RMT_LOG-1:0]      logDest;          // Architectural destination
    logic                          isLoad;
    logic                          isStore;
    logic [`CHECKPOINTS-1:0]       branchMask;       // Unresolved branches it depends on
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic [`SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] oldPhyDest;       // Freed at retire
    logic [`SIZE_OPCODE-1:0]       opcode;
    logic [`SIZE_IMMEDIATE-1:0]    immediate;
  } renamedPktT;

  // Issue queue entry, everything needed to wake up and execute
  typedef struct packed {
    logic [`SIZE_OPCODE-1:0]       opcode;
    logic [`SIZE_IMMEDIATE-1:0]    immediate;
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic [`SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [`CHECKPOINTS-1:0]       branchMask;       // Squash on mispredict
    logic                          isLoad;
    logic                          isStore;
  } issuePktT;

  // Active list entry, kept until retire
  typedef struct packed {
    logic [`SIZE_PC-1:0]           pc;
    logic [`SIZE_RMT_LOG-1:0]      logDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] phyDest;          // Committed to the AMT
    logic [`SIZE_PHYSICAL_LOG-1:0] oldPhyDest;       // Returned to the free list
    logic                          isLoad;
    logic                          isStore;
  } alPktT;

  // Load-store queue entry
  typedef struct packed {
    logic [`CHECKPOINTS-1:0]       branchMask;
    logic                          isStore;
    logic                          isLoad;
  } lsqPktT;

endpackage

`default_nettype wire

//--- source/dispatchTop.sv
`default_nettype none

`include "dispatch_consts.svh"

module dispatchTop (
  input  wire logic                          clk,
  input  wire logic                          rstN_i,
  input  wire logic                          renameReady_i,
  input  wire logic                          flagRecoverEX_i,
  input  wire logic                          ctrlVerified_i,
  input  wire logic [`CHECKPOINTS_LOG-1:0]   ctrlVerifiedTag_i,
  input  wire dispatchPkg::renamedPktT       renamedPacket_i [`DISPATCH_WIDTH],
  input  wire logic [`SIZE_LSQ_LOG:0]        loadQueueCnt_i,
  input  wire logic [`SIZE_LSQ_LOG:0]        storeQueueCnt_i,
  input  wire logic [`SIZE_ISSUEQ_LOG:0]     issueQueueCnt_i,
  input  wire logic [`SIZE_ACTIVELIST_LOG:0] activeListCnt_i,

  output dispatchPkg::issuePktT              issueqPacket_o [`DISPATCH_WIDTH],
  output dispatchPkg::alPktT                 alPacket_o [`DISPATCH_WIDTH],
  output dispatchPkg::lsqPktT                lsqPacket_o [`DISPATCH_WIDTH],
  output logic                               issueqValid_o,
  output logic                               alValid_o,
  output logic                               lsqValid_o,
  output logic [`CHECKPOINTS-1:0]            updatedBranchMask_o [`DISPATCH_WIDTH],
  output logic                               backEndReady_o,
  output logic                               stallFrontEnd_o
);

  import dispatchPkg::*;

  renamedPktT lanePkt [`DISPATCH_WIDTH];       // Renamed packet with updated mask
  logic       laneLoad [`DISPATCH_WIDTH];
  logic       laneStore [`DISPATCH_WIDTH];

  issuePktT   issuePkt [`DISPATCH_WIDTH];      // Back-end packets before the latch
  alPktT      alPkt [`DISPATCH_WIDTH];
  lsqPktT     lsqPkt [`DISPATCH_WIDTH];

  // Per-lane decode and packet forming
  for (genvar lane = 0; lane < `DISPATCH_WIDTH; lane++) begin : gLane
    laneDecode i_laneDecode (
      .renamedPkt_i        (renamedPacket_i[lane]),
      .ctrlVerified_i      (ctrlVerified_i),
      .ctrlVerifiedTag_i   (ctrlVerifiedTag_i),
      .lanePkt_o           (lanePkt[lane]),
      .isLoad_o            (laneLoad[lane]),
      .isStore_o           (laneStore[lane]),
      .updatedBranchMask_o (updatedBranchMask_o[lane])
    );

    packetBuild i_packetBuild (
      .lanePkt_i  (lanePkt[lane]),
      .issuePkt_o (issuePkt[lane]),
      .alPkt_o    (alPkt[lane]),
      .lsqPkt_o   (lsqPkt[lane])
    );
  end

  // Space check over the whole bundle
  resourceCheck i_resourceCheck (
    .isLoad_i        (laneLoad),
    .isStore_i       (laneStore),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .renameReady_i   (renameReady_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .backEndReady_o  (backEndReady_o),
    .stallFrontEnd_o (stallFrontEnd_o)
  );

  // Pipeline registers toward the back end, all loaded on the same accept
  dispatchLatch #(
    .payloadT (issuePktT)
  ) i_issueLatch (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (backEndReady_o),
    .payload_i (issuePkt),
    .payload_o (issueqPacket_o),
    .valid_o   (issueqValid_o)
  );

  dispatchLatch #(
    .payloadT (alPktT)
  ) i_alLatch (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (backEndReady_o),
    .payload_i (alPkt),
    .payload_o (alPacket_o),
    .valid_o   (alValid_o)
  );

  dispatchLatch #(
    .payloadT (lsqPktT)
  ) i_lsqLatch (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (backEndReady_o),
    .payload_i (lsqPkt),
    .payload_o (lsqPacket_o),
    .valid_o   (lsqValid_o)
  );

endmodule

`default_nettype wire

//--- source/laneDecode.sv
`default_nettype none

`include "dispatch_consts.svh"

module laneDecode (
  input  wire dispatchPkg::renamedPktT renamedPkt_i,
  input  wire logic                        ctrlVerified_i,    // A branch resolved correctly
  input  wire logic [`CHECKPOINTS_LOG-1:0] ctrlVerifiedTag_i, // Its checkpoint
  output dispatchPkg::renamedPktT      lanePkt_o,
  output logic                         isLoad_o,
  output logic                         isStore_o,
  output logic [`CHECKPOINTS-1:0]      updatedBranchMask_o // Back to the rename/dispatch register
);

  // Memory class of the lane
  assign isLoad_o  = renamedPkt_i.isLoad;
  assign isStore_o = renamedPkt_i.isStore;

  // The resolved branch no longer guards this instruction,
  // so its checkpoint bit drops out of the mask
  always_comb begin
    logic [`CHECKPOINTS-1:0] mask;

    mask = renamedPkt_i.branchMask;
    if (ctrlVerified_i) begin
      mask[ctrlVerifiedTag_i] = 1'b0;
    end
    updatedBranchMask_o = mask;
  end

  // Lane packet carries the new mask toward the back end
  always_comb begin
    lanePkt_o            = renamedPkt_i;
    lanePkt_o.branchMask = updatedBranchMask_o;
  end

endmodule

`default_nettype wire

//--- source/packetBuild.sv
`default_nettype none

module packetBuild (
  input  wire dispatchPkg::renamedPktT lanePkt_i,  // Mask already updated
  output dispatchPkg::issuePktT        issuePkt_o,
  output dispatchPkg::alPktT           alPkt_o,
  output dispatchPkg::lsqPktT          lsqPkt_o
);

  // Issue queue needs operands, op and the mask for squashing
  always_comb begin
    issuePkt_o.opcode     = lanePkt_i.opcode;
    issuePkt_o.immediate  = lanePkt_i.immediate;
    issuePkt_o.phySrc1    = lanePkt_i.phySrc1;
    issuePkt_o.phySrc2    = lanePkt_i.phySrc2;
    issuePkt_o.phyDest    = lanePkt_i.phyDest;
    issuePkt_o.branchMask = lanePkt_i.branchMask;
    issuePkt_o.isLoad     = lanePkt_i.isLoad;
    issuePkt_o.isStore    = lanePkt_i.isStore;
  end

  // Active list keeps what retire needs
  always_comb begin
    alPkt_o.pc         = lanePkt_i.pc;
    alPkt_o.logDest    = lanePkt_i.logDest;
    alPkt_o.phyDest    = lanePkt_i.phyDest;
    alPkt_o.oldPhyDest = lanePkt_i.oldPhyDest;
    alPkt_o.isLoad     = lanePkt_i.isLoad;
    alPkt_o.isStore    = lanePkt_i.isStore;
  end

  // LSQ only tracks the kind of access and its branch dependences
  always_comb begin
    lsqPkt_o.branchMask = lanePkt_i.branchMask;
    lsqPkt_o.isStore    = lanePkt_i.isStore;
    lsqPkt_o.isLoad     = lanePkt_i.isLoad;
  end

endmodule

`default_nettype wire

//--- source/resourceCheck.sv
`default_nettype none

`include "dispatch_consts.svh"

module resourceCheck (
  input  wire logic                            isLoad_i [`DISPATCH_WIDTH],
  input  wire logic                            isStore_i [`DISPATCH_WIDTH],
  input  wire logic [`SIZE_LSQ_LOG:0]          loadQueueCnt_i,  // Entries held in load queue
  input  wire logic [`SIZE_LSQ_LOG:0]          storeQueueCnt_i, // Entries held in store queue
  input  wire logic [`SIZE_ISSUEQ_LOG:0]       issueQueueCnt_i,
  input  wire logic [`SIZE_ACTIVELIST_LOG:0]   activeListCnt_i,
  input  wire logic                            renameReady_i,   // Rename holds a full bundle
  input  wire logic                            flagRecoverEX_i, // Mispredict recovery in progress
  output logic                                 backEndReady_o,
  output logic                                 stallFrontEnd_o
);

  localparam int CntW = $clog2(`DISPATCH_WIDTH + 1);

  logic [CntW-1:0] loadCnt;
  logic [CntW-1:0] storeCnt;
  logic            loadFull;
  logic            storeFull;
  logic            issueFull;
  logic            activeFull;

  // Loads and stores in this bundle
  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      loadCnt  = loadCnt + isLoad_i[i];
      storeCnt = storeCnt + isStore_i[i];
    end
  end

  // LSQ needs room only for the memory ops actually present
  assign loadFull  = (loadQueueCnt_i + loadCnt) > `SIZE_LSQ;
  assign storeFull = (storeQueueCnt_i + storeCnt) > `SIZE_LSQ;

  // Every lane takes an issue queue and an active list slot
  assign issueFull  = (issueQueueCnt_i + `DISPATCH_WIDTH) > `SIZE_ISSUEQ;
  assign activeFull = (activeListCnt_i + `DISPATCH_WIDTH) > `SIZE_ACTIVELIST;

  assign stallFrontEnd_o = loadFull | storeFull | issueFull | activeFull;

  /* The back end takes the bundle only when there is room, rename has
     one ready and no recovery is flushing the pipe */
  assign backEndReady_o = ~stallFrontEnd_o & renameReady_i & ~flagRecoverEX_i;

endmodule

`default_nettype wire

//--- testbench/dispatchTb.sv
`default_nettype none

`include "dispatch_consts.svh"

module dispatchTb;

  timeunit 1ns;
  timeprecision 100ps;

  import dispatchPkg::*;

  localparam int ValidTimeout = 8;                // Cycles allowed for a latched bundle

  logic                            clk = 1'b0;
  logic                            rstN;
  logic                            renameReady;
  logic                            flagRecoverEX;
  logic                            ctrlVerified;
  logic [`CHECKPOINTS_LOG-1:0]     ctrlVerifiedTag;
  renamedPktT                      renamedPacket [`DISPATCH_WIDTH];
  logic [`SIZE_LSQ_LOG:0]          loadQueueCnt;
  logic [`SIZE_LSQ_LOG:0]          storeQueueCnt;
  logic [`SIZE_ISSUEQ_LOG:0]       issueQueueCnt;
  logic [`SIZE_ACTIVELIST_LOG:0]   activeListCnt;

  issuePktT                        issueqPacket [`DISPATCH_WIDTH];
  alPktT                           alPacket [`DISPATCH_WIDTH];
  lsqPktT                          lsqPacket [`DISPATCH_WIDTH];
  logic                            issueqValid;
  logic                            alValid;
  logic                            lsqValid;
  logic [`CHECKPOINTS-1:0]         updatedBranchMask [`DISPATCH_WIDTH];
  logic                            backEndReady;
  logic                            stallFrontEnd;

  renamedPktT                      bundle [`DISPATCH_WIDTH]; // Next bundle to drive
  int                              checkCount = 0;
  int                              errorCount = 0;
  int                              testErrors = 0;        // Error count when a test starts

  always #2 clk = ~clk;                           // 4 ns period

  dispatchTop i_dut (
    .clk                 (clk),
    .rstN_i              (rstN),
    .renameReady_i       (renameReady),
    .flagRecoverEX_i     (flagRecoverEX),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedTag_i   (ctrlVerifiedTag),
    .renamedPacket_i     (renamedPacket),
    .loadQueueCnt_i      (loadQueueCnt),
    .storeQueueCnt_i     (storeQueueCnt),
    .issueQueueCnt_i     (issueQueueCnt),
    .activeListCnt_i     (activeListCnt),
    .issueqPacket_o      (issueqPacket),
    .alPacket_o          (alPacket),
    .lsqPacket_o         (lsqPacket),
    .issueqValid_o       (issueqValid),
    .alValid_o           (alValid),
    .lsqValid_o          (lsqValid),
    .updatedBranchMask_o (updatedBranchMask),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd)
  );

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("** Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic finishTest(input string name);
    $display("Test %s finished with %0d errors", name, errorCount - testErrors);
    testErrors = errorCount;
  endtask

  // Random fields, memory class chosen by the caller
  function automatic renamedPktT randomPkt(input logic isLoad, input logic isStore);
    logic [159:0] bits;
    renamedPktT   pkt;

    bits = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom()};
    pkt = bits[$bits(renamedPktT)-1:0];
    pkt.isLoad  = isLoad;
    pkt.isStore = isStore;
    return pkt;
  endfunction

  // A verified checkpoint no longer guards any instruction
  function automatic logic [`CHECKPOINTS-1:0] clearedMask(
      input logic [`CHECKPOINTS-1:0] mask, input logic verified,
      input logic [`CHECKPOINTS_LOG-1:0] tag);
    logic [`CHECKPOINTS-1:0] result;

    result = mask;
    if (verified) begin
      result[tag] = 1'b0;
    end
    return result;
  endfunction

  function automatic issuePktT expectIssue(input renamedPktT p, input logic verified,
                                           input logic [`CHECKPOINTS_LOG-1:0] tag);
    issuePktT e;

    e.opcode     = p.opcode;
    e.immediate  = p.immediate;
    e.phySrc1    = p.phySrc1;
    e.phySrc2    = p.phySrc2;
    e.phyDest    = p.phyDest;
    e.branchMask = clearedMask(p.branchMask, verified, tag);
    e.isLoad     = p.isLoad;
    e.isStore    = p.isStore;
    return e;
  endfunction

  function automatic alPktT expectAl(input renamedPktT p);
    alPktT e;

    e.pc         = p.pc;
    e.logDest    = p.logDest;
    e.phyDest    = p.phyDest;
    e.oldPhyDest = p.oldPhyDest;
    e.isLoad     = p.isLoad;
    e.isStore    = p.isStore;
    return e;
  endfunction

  function automatic lsqPktT expectLsq(input renamedPktT p, input logic verified,
                                       input logic [`CHECKPOINTS_LOG-1:0] tag);
    lsqPktT e;

    e.branchMask = clearedMask(p.branchMask, verified, tag);
    e.isStore    = p.isStore;
    e.isLoad     = p.isLoad;
    return e;
  endfunction

  // Drive on the rising edge, return at the falling edge where outputs are settled
  task automatic driveInputs(input logic ready, input logic recover, input logic verified,
                             input int tag, input int lq, input int sq, input int iq,
                             input int al);
    @(posedge clk);
    renameReady     <= ready;
    flagRecoverEX   <= recover;
    ctrlVerified    <= verified;
    ctrlVerifiedTag <= tag;
    loadQueueCnt    <= lq;
    storeQueueCnt   <= sq;
    issueQueueCnt   <= iq;
    activeListCnt   <= al;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      renamedPacket[i] <= bundle[i];
    end
    @(negedge clk);
  endtask

  // Nothing accepted, so all valids drop before the next test
  task automatic idle();
    driveInputs(1'b0, 1'b0, 1'b0, 0, 0, 0, 0, 0);
    @(negedge clk);
  endtask

  task automatic waitValid();
    int cycles;

    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!issueqValid && cycles < ValidTimeout);
    if (!issueqValid) begin
      errorCount++;
      $display("Timeout: no valid bundle from the dispatch latch after %0d cycles", cycles);
    end else begin
      checkValue("valid latency in cycles", cycles, 1);
    end
  endtask

  task automatic checkFlow(input logic expStall, input logic expReady);
    checkValue("stallFrontEnd_o", stallFrontEnd, expStall);
    checkValue("backEndReady_o", backEndReady, expReady);
  endtask

  task automatic checkValids(input logic expected);
    checkValue("issueqValid_o", issueqValid, expected);
    checkValue("alValid_o", alValid, expected);
    checkValue("lsqValid_o", lsqValid, expected);
  endtask

  task automatic checkLatched(input logic verified, input logic [`CHECKPOINTS_LOG-1:0] tag);
    checkValids(1'b1);
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      checkValue($sformatf("issueqPacket_o[%0d]", i), issueqPacket[i],
                 expectIssue(bundle[i], verified, tag));
      checkValue($sformatf("alPacket_o[%0d]", i), alPacket[i], expectAl(bundle[i]));
      checkValue($sformatf("lsqPacket_o[%0d]", i), lsqPacket[i],
                 expectLsq(bundle[i], verified, tag));
    end
  endtask

  // First lanes carry the loads or the stores
  task automatic setMemBundle(input int nLoads, input int nStores);
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      bundle[i] = randomPkt(i < nLoads, i < nStores);
    end
  endtask

  task automatic testReset();
    @(negedge clk);
    checkValids(1'b0);
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      checkValue($sformatf("issueqPacket_o[%0d]", i), issueqPacket[i], '0);
      checkValue($sformatf("alPacket_o[%0d]", i), alPacket[i], '0);
      checkValue($sformatf("lsqPacket_o[%0d]", i), lsqPacket[i], '0);
    end
    finishTest("reset");
  endtask

  task automatic testPassThrough();
    idle();
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      bundle[i] = randomPkt($urandom_range(0, 1), 1'b0);
      bundle[i].isStore = ~bundle[i].isLoad & $urandom_range(0, 1);
    end
    driveInputs(1'b1, 1'b0, 1'b0, 0, 0, 0, 0, 0);
    checkFlow(1'b0, 1'b1);
    waitValid();
    checkLatched(1'b0, '0);
    finishTest("passThrough");
  endtask

  task automatic testLsqSpace();
    idle();
    setMemBundle(3, 0);                           // One load too many
    driveInputs(1'b1, 1'b0, 1'b0, 0, `SIZE_LSQ - 2, 0, 0, 0);
    checkFlow(1'b1, 1'b0);
    setMemBundle(2, 0);
    driveInputs(1'b1, 1'b0, 1'b0, 0, `SIZE_LSQ - 2, 0, 0, 0);
    checkFlow(1'b0, 1'b1);
    setMemBundle(0, 3);
    driveInputs(1'b1, 1'b0, 1'b0, 0, 0, `SIZE_LSQ - 2, 0, 0);
    checkFlow(1'b1, 1'b0);
    setMemBundle(0, 2);
    driveInputs(1'b1, 1'b0, 1'b0, 0, 0, `SIZE_LSQ - 2, 0, 0);
    checkFlow(1'b0, 1'b1);
    finishTest("lsqSpace");
  endtask

  task automatic testQueueSpace();
    idle();
    setMemBundle(0, 0);
    driveInputs(1'b1, 1'b0, 1'b0, 0, 0, 0, `SIZE_ISSUEQ - `DISPATCH_WIDTH, 0);
    checkFlow(1'b0, 1'b1);
    driveInputs(1'b1, 1'b0, 1'b0, 0, 0, 0, `SIZE_ISSUEQ - `DISPATCH_WIDTH + 1, 0);
    checkFlow(1'b1, 1'b0);
    driveInputs(1'b1, 1'b0, 1'b0, 0, 0, 0, 0, `SIZE_ACTIVELIST - `DISPATCH_WIDTH);
    checkFlow(1'b0, 1'b1);
    driveInputs(1'b1, 1'b0, 1'b0, 0, 0, 0, 0, `SIZE_ACTIVELIST - `DISPATCH_WIDTH + 1);
    checkFlow(1'b1, 1'b0);
    finishTest("queueSpace");
  endtask

  task automatic testBranchMask();
    int tag;

    idle();
    tag = $urandom_range(0, `CHECKPOINTS - 1);
    for (int pass = 0; pass < 2; pass++) begin
      setMemBundle(1, 0);
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        bundle[i].branchMask[tag] = (i % 2 == 0); // Half the lanes depend on the branch
      end
      driveInputs(1'b1, 1'b0, pass == 0, tag, 0, 0, 0, 0);
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        checkValue($sformatf("updatedBranchMask_o[%0d]", i), updatedBranchMask[i],
                   clearedMask(bundle[i].branchMask, pass == 0, tag));
      end
      waitValid();
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        checkValue($sformatf("issueqPacket_o[%0d].branchMask", i),
                   issueqPacket[i].branchMask,
                   clearedMask(bundle[i].branchMask, pass == 0, tag));
        checkValue($sformatf("lsqPacket_o[%0d].branchMask", i), lsqPacket[i].branchMask,
                   clearedMask(bundle[i].branchMask, pass == 0, tag));
      end
    end
    finishTest("branchMask");
  endtask

  task automatic testRecovery();
    renamedPktT held [`DISPATCH_WIDTH];           // Last bundle the latches took

    held = bundle;
    idle();
    setMemBundle(1, 1);
    driveInputs(1'b1, 1'b1, 1'b0, 0, 0, 0, 0, 0);  // Recovery blocks an otherwise good bundle
    checkFlow(1'b0, 1'b0);
    @(negedge clk);
    checkValids(1'b0);
    driveInputs(1'b0, 1'b0, 1'b0, 0, 0, 0, 0, 0);  // Rename has nothing ready
    checkFlow(1'b0, 1'b0);
    @(negedge clk);
    checkValids(1'b0);
    driveInputs(1'b1, 1'b1, 1'b0, 0, 0, 0, `SIZE_ISSUEQ - `DISPATCH_WIDTH + 1, 0);
    checkFlow(1'b1, 1'b0);
    @(negedge clk);
    checkValids(1'b0);
    // Rejected bundles leave the registers as they were
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      checkValue($sformatf("issueqPacket_o[%0d]", i), issueqPacket[i],
                 expectIssue(held[i], 1'b0, '0));
      checkValue($sformatf("alPacket_o[%0d]", i), alPacket[i], expectAl(held[i]));
      checkValue($sformatf("lsqPacket_o[%0d]", i), lsqPacket[i],
                 expectLsq(held[i], 1'b0, '0));
    end
    finishTest("recovery");
  endtask

  initial begin
    void'($urandom(99749));
    rstN            <= 1'b0;
    renameReady     <= 1'b0;
    flagRecoverEX   <= 1'b0;
    ctrlVerified    <= 1'b0;
    ctrlVerifiedTag <= '0;
    loadQueueCnt    <= '0;
    storeQueueCnt   <= '0;
    issueQueueCnt   <= '0;
    activeListCnt   <= '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      renamedPacket[i] <= '0;
      bundle[i] = '0;
    end
    repeat (3) @(posedge clk);                    // Reset spans two full cycles
    rstN <= 1'b1;

    testReset();
    testPassThrough();
    testLsqSpace();
    testQueueSpace();
    testBranchMask();
    testRecovery();

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
